// ==== files.f ====
+incdir+sim
hdl/pow_pkg.sv
hdl/if_hdr_stream.sv
hdl/sha256_compress.sv
hdl/compact_target_decode.sv
hdl/sha256d_stream.sv
hdl/pow_difficulty_check.sv
sim/tb_pow_difficulty_check.sv

// ==== hdl/compact_target_decode.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compact difficulty word to 256-bit target, latched on i_load
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module compact_target_decode (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_load,
  input  logic [31:0]      i_bits,
  output pow_pkg::digest_t o_target,
  output logic             o_malformed
);

  logic [7:0]       expo;
  logic [22:0]      mant;
  pow_pkg::digest_t tgt_c;
  logic             bad_c;

  // Exponent byte counts the target length in bytes
  assign expo = i_bits[31:24];
  assign mant = i_bits[22:0];

  always_comb begin
    if (expo <= 8'd3) begin
      tgt_c = pow_pkg::digest_t'(mant) >> (8 * (3 - expo));
    end else begin
      tgt_c = pow_pkg::digest_t'(mant) << (8 * (expo - 3));
    end
    // Zero word, negative value, or target past 256 bits
    bad_c = (i_bits == 32'd0) ||
            (i_bits[23] && (mant != 23'd0)) ||
            ((mant != 23'd0) && (expo > pow_pkg::COMPACT_MAX_SIZE_3B)) ||
            ((mant > 23'hff) && (expo > pow_pkg::COMPACT_MAX_SIZE_2B)) ||
            ((mant > 23'hffff) && (expo > pow_pkg::COMPACT_MAX_SIZE_1B));
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_malformed <= 1'b0;
    end else if (i_load) begin
      o_malformed <= bad_c;
    end
  end

  // Held until the next load
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      o_target <= tgt_c;
    end
  end

endmodule

// ==== hdl/if_hdr_stream.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Valid/ready byte stream carrying one block header
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface if_hdr_stream;

  logic                                val;
  logic                                rdy;
  // Byte 0 is the earliest message byte
  logic [8*pow_pkg::STREAM_BYTES-1:0]  dat;
  // First and last beat of a header
  logic                                sop;
  logic                                eop;

  modport source (output val, dat, sop, eop, input rdy);
  modport sink   (input val, dat, sop, eop, output rdy);

endinterface

// ==== hdl/pow_difficulty_check.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Proof-of-work check of one block header per packet
// o_val pulses with the verdict on o_fail and the digest
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pow_difficulty_check (
  input  logic                               i_clk,
  input  logic                               i_rst,
  input  logic                               i_val,
  output logic                               o_rdy,
  input  logic [8*pow_pkg::STREAM_BYTES-1:0] i_dat,
  input  logic                               i_sop,
  input  logic                               i_eop,
  input  logic [31:0]                        i_bits,
  output logic                               o_val,
  output logic                               o_fail,
  output pow_pkg::digest_t                   o_digest
);

  if_hdr_stream hdr_if ();

  logic             tgt_load;
  logic             dig_val;
  pow_pkg::digest_t dig;
  pow_pkg::digest_t dig_le;
  pow_pkg::digest_t target;
  logic             malformed;

  assign hdr_if.val = i_val;
  assign hdr_if.dat = i_dat;
  assign hdr_if.sop = i_sop;
  assign hdr_if.eop = i_eop;
  assign o_rdy      = hdr_if.rdy;

  // Difficulty word rides on the accepted sop beat
  assign tgt_load = i_val && hdr_if.rdy && i_sop;

  // Digest byte 0 becomes the least significant byte
  always_comb begin
    for (int k = 0; k < 32; k++) begin
      dig_le[8*k +: 8] = dig[255-8*k -: 8];
    end
  end

  sha256d_stream u_hash (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .s_hdr        (hdr_if),
    .o_digest_val (dig_val),
    .o_digest     (dig)
  );

  compact_target_decode u_target (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_load      (tgt_load),
    .i_bits      (i_bits),
    .o_target    (target),
    .o_malformed (malformed)
  );

  // Verdict
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val  <= 1'b0;
      o_fail <= 1'b0;
    end else begin
      o_val <= dig_val;
      if (dig_val) begin
        o_fail <= malformed || (dig_le > target);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (dig_val) begin
      o_digest <= dig;
    end
  end

endmodule

// ==== hdl/pow_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants and types for the proof-of-work checker
// Referenced by scoped name from the RTL and the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package pow_pkg;

  // Bytes per stream beat and hashed header length
  localparam int STREAM_BYTES = 8;
  localparam int HEADER_BYTES = 80;

  // SHA-256 round constants
  localparam logic [31:0] SHA256_K [0:63] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Initial chaining value, word a in the top bits
  localparam logic [255:0] SHA256_H0 = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  // Exponent limits of the compact overflow check
  localparam int COMPACT_MAX_SIZE_1B = 32;
  localparam int COMPACT_MAX_SIZE_2B = 33;
  localparam int COMPACT_MAX_SIZE_3B = 34;

  // Digest or target value
  typedef logic [255:0] digest_t;

endpackage

// ==== hdl/sha256_compress.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SHA-256 compression, one round per clock
// Pulse i_start with block and chain, o_done follows 65 clocks later
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sha256_compress (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_start,
  input  logic [511:0]     i_block,
  input  pow_pkg::digest_t i_chain,
  output logic             o_done,
  output pow_pkg::digest_t o_chain
);

  logic             busy;
  logic [5:0]       rnd;
  logic [31:0]      a, b, c, d, e, f, g, h;
  // Sliding schedule window, w[0] is the word of the current round
  logic [31:0]      w [16];
  pow_pkg::digest_t chain_q;
  logic [31:0]      t1, t2, w_next;

  function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
    rotr = (x >> n) | (x << (32 - n));
  endfunction

  function automatic logic [31:0] big_sigma0(input logic [31:0] x);
    big_sigma0 = rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic logic [31:0] big_sigma1(input logic [31:0] x);
    big_sigma1 = rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  function automatic logic [31:0] small_sigma0(input logic [31:0] x);
    small_sigma0 = rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic logic [31:0] small_sigma1(input logic [31:0] x);
    small_sigma1 = rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  // Round datapath
  always_comb begin
    t1 = h + big_sigma1(e) + ((e & f) ^ (~e & g)) + pow_pkg::SHA256_K[rnd] + w[0];
    t2 = big_sigma0(a) + ((a & b) ^ (a & c) ^ (b & c));
    // Schedule word sixteen rounds ahead
    w_next = small_sigma1(w[14]) + w[9] + small_sigma0(w[1]) + w[0];
  end

  // Round sequencing
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy   <= 1'b0;
      rnd    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy <= 1'b1;
        rnd  <= '0;
      end else if (busy) begin
        rnd <= rnd + 6'd1;
        // Last round lands here, done flags the following cycle
        if (rnd == 6'd63) begin
          busy   <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

  // Working variables and schedule window
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      chain_q                  <= i_chain;
      {a, b, c, d, e, f, g, h} <= i_chain;
      // Block words are big-endian, word 0 on top
      for (int j = 0; j < 16; j++) begin
        w[j] <= i_block[511-32*j -: 32];
      end
    end else if (busy) begin
      h <= g;
      g <= f;
      f <= e;
      e <= d + t1;
      d <= c;
      c <= b;
      b <= a;
      a <= t1 + t2;
      for (int j = 0; j < 15; j++) begin
        w[j] <= w[j+1];
      end
      w[15] <= w_next;
    end
  end

  // Feed-forward add onto the incoming chain
  assign o_chain = {
    chain_q[255:224] + a, chain_q[223:192] + b,
    chain_q[191:160] + c, chain_q[159:128] + d,
    chain_q[127:96]  + e, chain_q[95:64]   + f,
    chain_q[63:32]   + g, chain_q[31:0]    + h
  };

  // Caller waits for o_done before the next block
  a_no_restart : assert property (@(posedge i_clk) disable iff (i_rst) busy |-> !i_start)
    else $error("sha256_compress: start while a block is in flight");

endmodule

// ==== hdl/sha256d_stream.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Double SHA-256 over the header bytes of a byte stream
// Surplus beats up to eop are dropped, digest pulses on o_digest_val
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sha256d_stream (
  input  logic             i_clk,
  input  logic             i_rst,
  if_hdr_stream.sink       s_hdr,
  output logic             o_digest_val,
  output pow_pkg::digest_t o_digest
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FILL,
    S_COMP,
    S_LAST,
    S_HASH2
  } state_t;

  state_t                                     state;
  logic                                       hdr_xfer;
  logic                                       start;
  logic                                       drain;
  logic [$clog2(pow_pkg::HEADER_BYTES+1)-1:0] byt_cnt;
  logic [$clog2(pow_pkg::HEADER_BYTES+1)-1:0] byt_nxt;
  logic [8*pow_pkg::STREAM_BYTES-1:0]         beat_be;
  logic [511:0]                               blk;
  logic [511:0]                               pad_blk;
  logic [511:0]                               cmp_blk;
  pow_pkg::digest_t                           mid;
  pow_pkg::digest_t                           cmp_chain;
  logic                                       cmp_done;
  pow_pkg::digest_t                           cmp_out;

  // Ready in idle and filling, and while draining surplus beats
  assign s_hdr.rdy = (state == S_IDLE) || (state == S_FILL) || ((state == S_HASH2) && drain);
  assign hdr_xfer  = s_hdr.val && s_hdr.rdy;
  assign byt_nxt   = byt_cnt + $bits(byt_cnt)'(pow_pkg::STREAM_BYTES);

  // Beat byte 0 goes to the most significant byte
  always_comb begin
    for (int k = 0; k < pow_pkg::STREAM_BYTES; k++) begin
      beat_be[8*(pow_pkg::STREAM_BYTES-1-k) +: 8] = s_hdr.dat[8*k +: 8];
    end
  end

  // Final header block: tail bytes, 0x80, zeros, bit length
  assign pad_blk = {
    blk[8*(pow_pkg::HEADER_BYTES%64)-1:0],
    8'h80,
    {(440-8*(pow_pkg::HEADER_BYTES%64)){1'b0}},
    64'(8*pow_pkg::HEADER_BYTES)
  };

  // Block and chain to the compressor, chosen by state
  always_comb begin
    case (state)
      S_LAST:  cmp_blk = pad_blk;
      // Second pass hashes the 32-byte first digest
      S_HASH2: cmp_blk = {mid, 8'h80, 184'd0, 64'd256};
      default: cmp_blk = blk;
    endcase
    cmp_chain = (state == S_HASH2) ? pow_pkg::SHA256_H0 : mid;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state        <= S_IDLE;
      start        <= 1'b0;
      drain        <= 1'b0;
      byt_cnt      <= '0;
      o_digest_val <= 1'b0;
    end else begin
      start        <= 1'b0;
      o_digest_val <= 1'b0;
      case (state)
        S_IDLE: begin
          // Non-sop beats here are leftovers and get dropped
          if (hdr_xfer && s_hdr.sop) begin
            byt_cnt <= $bits(byt_cnt)'(pow_pkg::STREAM_BYTES);
            state   <= S_FILL;
          end
        end
        S_FILL: begin
          if (hdr_xfer) begin
            byt_cnt <= byt_nxt;
            if (byt_nxt == $bits(byt_nxt)'(pow_pkg::HEADER_BYTES)) begin
              start <= 1'b1;
              drain <= !s_hdr.eop;
              state <= S_LAST;
            end else if (byt_nxt[5:0] == 6'd0) begin
              start <= 1'b1;
              state <= S_COMP;
            end
          end
        end
        S_COMP: begin
          if (cmp_done) begin
            state <= S_FILL;
          end
        end
        S_LAST: begin
          // First digest done, chain straight into the second pass
          if (cmp_done) begin
            start <= 1'b1;
            state <= S_HASH2;
          end
        end
        S_HASH2: begin
          if (hdr_xfer && s_hdr.eop) begin
            drain <= 1'b0;
          end
          if (cmp_done) begin
            o_digest_val <= 1'b1;
            state        <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Block buffer, mid-state and digest
  always_ff @(posedge i_clk) begin
    if (hdr_xfer && ((state == S_FILL) || ((state == S_IDLE) && s_hdr.sop))) begin
      blk <= {blk[511-8*pow_pkg::STREAM_BYTES:0], beat_be};
    end
    if ((state == S_IDLE) && hdr_xfer && s_hdr.sop) begin
      mid <= pow_pkg::SHA256_H0;
    end else if (cmp_done && (state != S_HASH2)) begin
      mid <= cmp_out;
    end
    if (cmp_done && (state == S_HASH2)) begin
      o_digest <= cmp_out;
    end
  end

  sha256_compress u_compress (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (start),
    .i_block (cmp_blk),
    .i_chain (cmp_chain),
    .o_done  (cmp_done),
    .o_chain (cmp_out)
  );

  // A new header only starts once the previous digest is out
  a_sop_idle : assert property (@(posedge i_clk) disable iff (i_rst)
    hdr_xfer && s_hdr.sop |-> state == S_IDLE)
    else $error("sha256d_stream: sop accepted outside idle");

  // Source holds a stalled beat until it is taken
  a_hold_beat : assert property (@(posedge i_clk) disable iff (i_rst)
    s_hdr.val && !s_hdr.rdy |=> s_hdr.val && $stable(s_hdr.dat) &&
      $stable(s_hdr.sop) && $stable(s_hdr.eop))
    else $error("sha256d_stream: stalled beat changed before transfer");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the proof-of-work checker testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal -Mdir obj_dir \
  --top-module tb_pow_difficulty_check -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_pow_difficulty_check > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0

// ==== sim/sha256_model.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference SHA-256, double hash and compact decode for the testbench
// Included inside the testbench module, call init_sha_consts first
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SHA256_MODEL_SVH
`define SHA256_MODEL_SVH

// Round constants and initial hash words, rebuilt from the primes
logic [31:0] ref_k [64];
logic [31:0] ref_h [8];

function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
  logic [63:0] both;
  both = {x, x} >> n;
  return both[31:0];
endfunction

// Fraction bits of cube roots (K) and square roots (H) of the first primes
function automatic void init_sha_consts();
  int           p;
  int           found;
  logic         prime;
  logic [127:0] n;
  found = 0;
  p = 2;
  while (found < 64) begin
    prime = 1'b1;
    for (int d = 2; d * d <= p; d++) begin
      if (p % d == 0) prime = 1'b0;
    end
    if (prime) begin
      // Real estimate, then exact integer correction
      n = 128'(longint'($pow(real'(p), 1.0 / 3.0) * 4294967296.0));
      while ((n + 1) * (n + 1) * (n + 1) <= (128'(p) << 96)) n++;
      while (n * n * n > (128'(p) << 96)) n--;
      ref_k[found] = n[31:0];
      if (found < 8) begin
        n = 128'(longint'($sqrt(real'(p)) * 4294967296.0));
        while ((n + 1) * (n + 1) <= (128'(p) << 64)) n++;
        while (n * n > (128'(p) << 64)) n--;
        ref_h[found] = n[31:0];
      end
      found++;
    end
    p++;
  end
endfunction

// Plain SHA-256 of a byte message, byte 0 of the digest on top
function automatic pow_pkg::digest_t sha256_bytes(input logic [7:0] msg [$]);
  logic [7:0]  buf_q [$];
  logic [31:0] w [64];
  logic [31:0] hv [8];
  logic [31:0] v [8];
  logic [31:0] s0, s1, ch, maj, t1, t2;
  logic [63:0] bit_len;
  buf_q = msg;
  bit_len = 64'(msg.size()) * 64'd8;
  buf_q.push_back(8'h80);
  while (buf_q.size() % 64 != 56) buf_q.push_back(8'h00);
  for (int k = 7; k >= 0; k--) buf_q.push_back(bit_len[8*k +: 8]);
  hv = ref_h;
  for (int b = 0; b < buf_q.size() / 64; b++) begin
    // Full 64-word schedule
    for (int t = 0; t < 64; t++) begin
      if (t < 16) begin
        w[t] = {buf_q[64*b+4*t], buf_q[64*b+4*t+1], buf_q[64*b+4*t+2], buf_q[64*b+4*t+3]};
      end else begin
        s0 = ror32(w[t-15], 7) ^ ror32(w[t-15], 18) ^ (w[t-15] >> 3);
        s1 = ror32(w[t-2], 17) ^ ror32(w[t-2], 19) ^ (w[t-2] >> 10);
        w[t] = w[t-16] + s0 + w[t-7] + s1;
      end
    end
    v = hv;
    for (int t = 0; t < 64; t++) begin
      s1 = ror32(v[4], 6) ^ ror32(v[4], 11) ^ ror32(v[4], 25);
      ch = (v[4] & v[5]) ^ (~v[4] & v[6]);
      t1 = v[7] + s1 + ch + ref_k[t] + w[t];
      s0 = ror32(v[0], 2) ^ ror32(v[0], 13) ^ ror32(v[0], 22);
      maj = (v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]);
      t2 = s0 + maj;
      for (int k = 7; k > 0; k--) v[k] = v[k-1];
      v[4] = v[4] + t1;
      v[0] = t1 + t2;
    end
    for (int k = 0; k < 8; k++) hv[k] = hv[k] + v[k];
  end
  return {hv[0], hv[1], hv[2], hv[3], hv[4], hv[5], hv[6], hv[7]};
endfunction

// Hash of the hash of the header bytes
function automatic pow_pkg::digest_t sha256d_header(input logic [7:0] hdr [pow_pkg::HEADER_BYTES]);
  logic [7:0]       msg [$];
  pow_pkg::digest_t first;
  foreach (hdr[k]) msg.push_back(hdr[k]);
  first = sha256_bytes(msg);
  msg.delete();
  for (int k = 0; k < 32; k++) msg.push_back(first[255-8*k -: 8]);
  return sha256_bytes(msg);
endfunction

// Mantissa scaled by 256 to the power of exponent minus 3
function automatic pow_pkg::digest_t compact_target(input logic [31:0] bits);
  pow_pkg::digest_t t;
  int               ex;
  ex = int'(bits[31:24]);
  t = 256'(bits[22:0]);
  for (int i = ex; i < 3; i++) t = t >> 8;
  for (int i = 3; i < ex; i++) t = t << 8;
  return t;
endfunction

function automatic logic compact_malformed(input logic [31:0] bits);
  int ex;
  int mant;
  ex = int'(bits[31:24]);
  mant = int'(bits[22:0]);
  return (bits == 32'd0) || (bits[23] && mant != 0) || (mant != 0 && ex > 34) ||
         (mant > 'hff && ex > 33) || (mant > 'hffff && ex > 32);
endfunction

// Digest read little-endian against the decoded target
function automatic logic expect_fail(input pow_pkg::digest_t dig, input logic [31:0] bits);
  pow_pkg::digest_t le;
  le = {<<8{dig}};
  return compact_malformed(bits) || (le > compact_target(bits));
endfunction

`endif

// ==== sim/tb_pow_difficulty_check.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the proof-of-work checker, random headers from seed 21
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_pow_difficulty_check;

  localparam int CLK_HALF_NS   = 2;
  localparam int RESET_CYCLES  = 16;
  localparam int BEAT_TIMEOUT  = 400;
  localparam int DRAIN_TIMEOUT = 2000;
  localparam logic [31:0] EASY_BITS = 32'h207fffff;

  logic                               i_clk;
  logic                               i_rst;
  logic                               i_val;
  logic                               o_rdy;
  logic [8*pow_pkg::STREAM_BYTES-1:0] i_dat;
  logic                               i_sop;
  logic                               i_eop;
  logic [31:0]                        i_bits;
  logic                               o_val;
  logic                               o_fail;
  pow_pkg::digest_t                   o_digest;

  // Expected results, one entry per header in flight
  pow_pkg::digest_t exp_digest_q [$];
  logic             exp_fail_q [$];
  int               value_errs = 0;
  int               other_errs = 0;
  int               timeouts = 0;
  int               checked = 0;

  `include "sha256_model.svh"

  pow_difficulty_check i_dut (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_val    (i_val),
    .o_rdy    (o_rdy),
    .i_dat    (i_dat),
    .i_sop    (i_sop),
    .i_eop    (i_eop),
    .i_bits   (i_bits),
    .o_val    (o_val),
    .o_fail   (o_fail),
    .o_digest (o_digest)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_HALF_NS) i_clk = ~i_clk;
  end

  task automatic finish_run();
    $display("Checked %0d results: %0d value errors, %0d protocol errors, %0d timeouts",
             checked, value_errs, other_errs, timeouts);
    if (value_errs == 0 && other_errs == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t ns: %s", $time, what);
  endtask

  // Beats go out on falling edges, held while o_rdy is low
  task automatic send_header(input logic [7:0] hdr [pow_pkg::HEADER_BYTES],
                             input logic [31:0] bits, input int extra_beats);
    int n_beats;
    int gap;
    int wait_cnt;
    int idx;
    n_beats = pow_pkg::HEADER_BYTES / pow_pkg::STREAM_BYTES + extra_beats;
    for (int bt = 0; bt < n_beats && timeouts == 0; bt++) begin
      gap = ($urandom % 4 == 0) ? 1 + $urandom % 3 : 0;
      repeat (gap) begin
        @(negedge i_clk);
        i_val = 1'b0;
      end
      @(negedge i_clk);
      i_val  = 1'b1;
      i_sop  = (bt == 0);
      i_eop  = (bt == n_beats - 1);
      i_bits = bits;
      for (int k = 0; k < pow_pkg::STREAM_BYTES; k++) begin
        idx = bt * pow_pkg::STREAM_BYTES + k;
        // Surplus bytes are random filler
        i_dat[8*k +: 8] = (idx < pow_pkg::HEADER_BYTES) ? hdr[idx] : 8'($urandom);
      end
      wait_cnt = 0;
      while (!o_rdy && wait_cnt < BEAT_TIMEOUT) begin
        @(negedge i_clk);
        wait_cnt++;
      end
      if (!o_rdy) report_timeout("the DUT kept o_rdy low with a beat waiting");
    end
    @(negedge i_clk);
    i_val = 1'b0;
    i_sop = 1'b0;
    i_eop = 1'b0;
  endtask

  task automatic run_header(input logic [31:0] bits, input int extra_beats,
                            input logic must_fail);
    logic [7:0]       hdr [pow_pkg::HEADER_BYTES];
    pow_pkg::digest_t dig;
    if (timeouts == 0) begin
      foreach (hdr[k]) hdr[k] = 8'($urandom);
      dig = sha256d_header(hdr);
      exp_digest_q.push_back(dig);
      // Malformed words fail whatever the digest
      exp_fail_q.push_back(must_fail ? 1'b1 : expect_fail(dig, bits));
      send_header(hdr, bits, extra_beats);
    end
  endtask

  // Results sampled mid-cycle, away from the rising edge
  always @(negedge i_clk) begin
    pow_pkg::digest_t exp_d;
    logic             exp_f;
    if (!i_rst && o_val) begin
      if (exp_fail_q.size() == 0) begin
        other_errs++;
        $display("Unexpected result pulse at %0t ns with no header outstanding", $time);
      end else begin
        exp_d = exp_digest_q.pop_front();
        exp_f = exp_fail_q.pop_front();
        checked++;
        assert (o_digest == exp_d) else begin
          value_errs++;
          $display("FAILED at %0t ns: digest %h, expected %h", $time, o_digest, exp_d);
        end
        assert (o_fail == exp_f) else begin
          value_errs++;
          $display("FAILED at %0t ns: o_fail %b, expected %b", $time, o_fail, exp_f);
        end
      end
    end
  end

  initial begin
    logic [31:0] bad_words [5];
    int          wait_cnt;
    // Zero, sign, then one word per overflow limit, mostly with large truncated targets
    bad_words = '{32'h00000000, 32'h2180ffff, 32'h23000001, 32'h2200ffff, 32'h217fffff};
    void'($urandom(21));
    i_rst  = 1'b1;
    i_val  = 1'b0;
    i_sop  = 1'b0;
    i_eop  = 1'b0;
    i_dat  = '0;
    i_bits = '0;
    init_sha_consts();
    repeat (RESET_CYCLES) @(negedge i_clk);
    i_rst = 1'b0;
    @(negedge i_clk);
    assert (!o_val && o_rdy) else begin
      value_errs++;
      $display("FAILED at %0t ns: idle outputs after reset o_val %b o_rdy %b",
               $time, o_val, o_rdy);
    end
    // Generous target
    repeat (4) run_header(EASY_BITS, 0, 1'b0);
    // Small exponents, mostly hard targets
    repeat (4) run_header({8'($urandom % 33), 1'b0, 23'($urandom)}, 0, 1'b0);
    foreach (bad_words[k]) run_header(bad_words[k], 0, 1'b1);
    // Surplus beats before eop, then a bare header
    for (int x = 1; x <= 4; x++) begin
      run_header(EASY_BITS, x, 1'b0);
      run_header(EASY_BITS, 0, 1'b0);
    end
    repeat (20) begin
      run_header(($urandom % 2) ? EASY_BITS : {8'h1d + 8'($urandom % 4), 1'b0, 23'($urandom)},
                 0, 1'b0);
    end
    wait_cnt = 0;
    while (exp_fail_q.size() != 0 && timeouts == 0 && wait_cnt < DRAIN_TIMEOUT) begin
      @(negedge i_clk);
      wait_cnt++;
    end
    if (exp_fail_q.size() != 0 && timeouts == 0) begin
      report_timeout("results still outstanding at the end");
    end
    // Quiet tail to catch stray result pulses
    repeat (50) @(negedge i_clk);
    finish_run();
  end

endmodule
